//--- project.f
rtl/uop_pkg.sv
rtl/dbus_pkg.sv
rtl/mem_op_unit.sv
rtl/dbus_unit.sv
rtl/wb_merge.sv
rtl/mem_stage.sv
tests/tb_mem_stage.sv

//--- rtl/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int bus_bytes = 4;
    localparam int offset_w  = $clog2(bus_bytes);

    typedef logic [addr_w-1:0]    addr_t;
    typedef logic [data_w-1:0]    data_t;
    typedef logic [bus_bytes-1:0] mask_t;
    typedef logic [offset_w-1:0]  offset_t;
    typedef logic [1:0]           size_t;

    // access size encoding
    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    typedef struct packed {
        addr_t addr;    // word aligned
        logic  write;
        data_t wdata;
        mask_t mask;
    } dbus_req_t;

    typedef struct packed {
        logic      active;
        logic      is_load;
        dbus_req_t req;
        offset_t   offset;  // byte within the word
        size_t     size;
        logic      sign;
    } access_t;

endpackage

`default_nettype wire

//--- rtl/dbus_unit.sv
`timescale 1ns/1ns
`default_nettype none

module dbus_unit (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  dbus_pkg::access_t   access_i,

    // l1 request channel
    output dbus_pkg::dbus_req_t l1_req_o,
    output logic                l1_req_valid_o,
    input  logic                l1_req_ready_i,

    // l1 response channel
    input  dbus_pkg::data_t     l1_rsp_data_i,
    input  logic                l1_rsp_valid_i,
    output logic                l1_rsp_ready_o,

    output logic                stall_o,
    output logic                done_o,
    output dbus_pkg::data_t     load_data_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_rsp,
        st_done
    } state_t;

    state_t              state_q;
    state_t              state_d;
    dbus_pkg::dbus_req_t req_q;
    dbus_pkg::data_t     load_data_q;
    logic                req_fire;
    logic                rsp_fire;

    assign req_fire = l1_req_valid_o && l1_req_ready_i;
    assign rsp_fire = l1_rsp_valid_i && l1_rsp_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (access_i.active) begin
                    state_d = st_req;
                end
            end
            st_req: begin
                if (req_fire) begin
                    // stores get no response
                    state_d = req_q.write ? st_done : st_wait_rsp;
                end
            end
            st_wait_rsp: begin
                if (rsp_fire) begin
                    state_d = st_done;
                end
            end
            default: state_d = st_idle;   // done lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // request frozen while the port back-pressures
    always_ff @(posedge clk_i) begin
        if (state_q == st_idle && access_i.active) begin
            req_q <= access_i.req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_fire) begin
            load_data_q <= l1_rsp_data_i;
        end
    end

    assign l1_req_o       = req_q;
    assign l1_req_valid_o = (state_q == st_req);
    assign l1_rsp_ready_o = (state_q == st_wait_rsp);

    assign stall_o = (state_q == st_idle && access_i.active) ||
                     (state_q == st_req) ||
                     (state_q == st_wait_rsp);
    assign done_o      = (state_q == st_done);
    assign load_data_o = load_data_q;

endmodule

`default_nettype wire

//--- rtl/mem_op_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_op_unit (
    input  uop_pkg::uop_t     uop_i,
    output dbus_pkg::access_t access_o
);

    dbus_pkg::addr_t   eff_addr;
    dbus_pkg::offset_t offset;
    dbus_pkg::size_t   size;
    dbus_pkg::mask_t   base_mask;
    dbus_pkg::data_t   lane_data;
    logic              sign;
    logic              is_load;
    logic              is_mem;

    assign eff_addr = uop_i.rs1 + uop_i.imm;
    assign offset   = eff_addr[dbus_pkg::offset_w-1:0];

    // operation decode
    always_comb begin
        size    = dbus_pkg::size_word;
        sign    = 1'b0;
        is_load = 1'b0;
        is_mem  = 1'b1;
        case (uop_i.mem_op)
            uop_pkg::mem_lb: begin
                size    = dbus_pkg::size_byte;
                sign    = 1'b1;
                is_load = 1'b1;
            end
            uop_pkg::mem_lh: begin
                size    = dbus_pkg::size_half;
                sign    = 1'b1;
                is_load = 1'b1;
            end
            uop_pkg::mem_lw: begin
                is_load = 1'b1;
            end
            uop_pkg::mem_lbu: begin
                size    = dbus_pkg::size_byte;
                is_load = 1'b1;
            end
            uop_pkg::mem_lhu: begin
                size    = dbus_pkg::size_half;
                is_load = 1'b1;
            end
            uop_pkg::mem_sb: size = dbus_pkg::size_byte;
            uop_pkg::mem_sh: size = dbus_pkg::size_half;
            uop_pkg::mem_sw: size = dbus_pkg::size_word;
            default: is_mem = 1'b0;   // mem_none
        endcase
    end

    // lanes at offset zero, shifted into place below
    always_comb begin
        case (size)
            dbus_pkg::size_byte: base_mask = dbus_pkg::mask_t'(1);
            dbus_pkg::size_half: base_mask = dbus_pkg::mask_t'(3);
            default:             base_mask = '1;
        endcase
    end

    // every lane gets a copy, the mask picks the live one
    always_comb begin
        case (size)
            dbus_pkg::size_byte: lane_data = {dbus_pkg::bus_bytes{uop_i.rs2[7:0]}};
            dbus_pkg::size_half: lane_data = {(dbus_pkg::bus_bytes / 2){uop_i.rs2[15:0]}};
            default:             lane_data = uop_i.rs2;
        endcase
    end

    always_comb begin
        access_o.active    = uop_i.valid && is_mem;
        access_o.is_load   = is_load;
        access_o.req.addr  = {eff_addr[dbus_pkg::addr_w-1:dbus_pkg::offset_w],
                              {dbus_pkg::offset_w{1'b0}}};
        access_o.req.write = is_mem && !is_load;
        access_o.req.wdata = lane_data;
        access_o.req.mask  = base_mask << offset;
        access_o.offset    = offset;
        access_o.size      = size;
        access_o.sign      = sign;
    end

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  logic                clk_i,
    input  logic                rstn_i,

    // from execute
    input  uop_pkg::uop_t       uop_i,
    output logic                stall_o,

    // to writeback
    output uop_pkg::uop_t       wb_uop_o,

    // l1 data port
    output dbus_pkg::dbus_req_t l1_req_o,
    output logic                l1_req_valid_o,
    input  logic                l1_req_ready_i,
    input  dbus_pkg::data_t     l1_rsp_data_i,
    input  logic                l1_rsp_valid_i,
    output logic                l1_rsp_ready_o
);

    dbus_pkg::access_t access;
    dbus_pkg::data_t   load_data;
    logic              done;

    mem_op_unit mem_op_unit_i (
        .uop_i          ( uop_i          ),
        .access_o       ( access         )
    );

    dbus_unit dbus_unit_i (
        .clk_i          ( clk_i          ),
        .rstn_i         ( rstn_i         ),
        .access_i       ( access         ),
        .l1_req_o       ( l1_req_o       ),
        .l1_req_valid_o ( l1_req_valid_o ),
        .l1_req_ready_i ( l1_req_ready_i ),
        .l1_rsp_data_i  ( l1_rsp_data_i  ),
        .l1_rsp_valid_i ( l1_rsp_valid_i ),
        .l1_rsp_ready_o ( l1_rsp_ready_o ),
        .stall_o        ( stall_o        ),
        .done_o         ( done           ),
        .load_data_o    ( load_data      )
    );

    wb_merge wb_merge_i (
        .clk_i          ( clk_i          ),
        .rstn_i         ( rstn_i         ),
        .uop_i          ( uop_i          ),
        .access_i       ( access         ),
        .stall_i        ( stall_o        ),   // same level execute sees
        .done_i         ( done           ),
        .load_data_i    ( load_data      ),
        .wb_uop_o       ( wb_uop_o       )
    );

endmodule

`default_nettype wire

//--- rtl/uop_pkg.sv
`default_nettype none

package uop_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int tag_w     = 4;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [tag_w-1:0]     tag_t;

    // memory operation carried by the uop
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;      // ordering through the pipe
        mem_op_t  mem_op;
        word_t    rs1;      // base
        word_t    rs2;      // store value
        word_t    imm;      // already sign extended
        reg_idx_t rd;
        word_t    result;
    } uop_t;

endpackage

`default_nettype wire

//--- rtl/wb_merge.sv
`timescale 1ns/1ns
`default_nettype none

module wb_merge (
    input  logic              clk_i,
    input  logic              rstn_i,

    input  uop_pkg::uop_t     uop_i,
    input  dbus_pkg::access_t access_i,

    input  logic              stall_i,
    input  logic              done_i,
    input  dbus_pkg::data_t   load_data_i,

    output uop_pkg::uop_t     wb_uop_o
);

    uop_pkg::word_t shifted;
    uop_pkg::word_t ext_data;
    uop_pkg::uop_t  next_uop;
    uop_pkg::uop_t  uop_q;
    logic           valid_q;

    // addressed byte or half down to lane 0
    assign shifted = load_data_i >> {access_i.offset, 3'b000};

    always_comb begin
        case (access_i.size)
            dbus_pkg::size_byte: begin
                ext_data = {{(uop_pkg::xlen - 8){access_i.sign & shifted[7]}},
                            shifted[7:0]};
            end
            dbus_pkg::size_half: begin
                ext_data = {{(uop_pkg::xlen - 16){access_i.sign & shifted[15]}},
                            shifted[15:0]};
            end
            default: ext_data = shifted;
        endcase
    end

    always_comb begin
        next_uop = uop_i;
        if (done_i && access_i.is_load) begin
            next_uop.result = ext_data;   // loaded value replaces result
        end
    end

    // bubble while the stage is stalled
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= !stall_i && uop_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            uop_q <= next_uop;
        end
    end

    always_comb begin
        wb_uop_o       = uop_q;
        wb_uop_o.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the memory stage testbench, output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f project.f --top-module tb_mem_stage -o sim_mem_stage \
    && ./obj_dir/sim_mem_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation reported failure"; exit 1; }
exit 0

//--- tests/tb_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;

    localparam int             num_uops   = 400;
    localparam int             max_cycles = num_uops * 12;
    localparam uop_pkg::word_t mem_base   = 32'h0000_1000;   // 64 word window

    logic                clk_i;
    logic                rstn_i;
    uop_pkg::uop_t       uop_i;
    logic                stall_o;
    uop_pkg::uop_t       wb_uop_o;
    dbus_pkg::dbus_req_t l1_req_o;
    logic                l1_req_valid_o;
    logic                l1_req_ready_i = 1'b0;
    dbus_pkg::data_t     l1_rsp_data_i  = '0;
    logic                l1_rsp_valid_i = 1'b0;
    logic                l1_rsp_ready_o;

    integer          seed;
    int              value_errors = 0;
    int              other_errors = 0;
    int              cycles       = 0;
    int              issued_valid = 0;
    int              accepted     = 0;
    int              wb_seen      = 0;
    int              req_count    = 0;
    int              req_wait     = 0;
    int              rsp_wait     = 0;
    logic            wb_due       = 1'b0;
    logic            hold_pending = 1'b0;
    dbus_pkg::dbus_req_t held_req;
    uop_pkg::tag_t   tag_cnt      = '0;
    dbus_pkg::data_t model_mem [64];
    dbus_pkg::data_t resp_mem  [64];
    uop_pkg::uop_t   wb_queue  [$];

    mem_stage mem_stage_i (
        .clk_i          ( clk_i          ),
        .rstn_i         ( rstn_i         ),
        .uop_i          ( uop_i          ),
        .stall_o        ( stall_o        ),
        .wb_uop_o       ( wb_uop_o       ),
        .l1_req_o       ( l1_req_o       ),
        .l1_req_valid_o ( l1_req_valid_o ),
        .l1_req_ready_i ( l1_req_ready_i ),
        .l1_rsp_data_i  ( l1_rsp_data_i  ),
        .l1_rsp_valid_i ( l1_rsp_valid_i ),
        .l1_rsp_ready_o ( l1_rsp_ready_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic int rand_delay();
        logic [31:0] r;
        r = rand_word();
        return int'(r[1:0]);   // 0 to 3 cycles
    endfunction

    function automatic dbus_pkg::data_t fill_word(int idx);
        return 32'h1357_9bdf ^ (32'(idx) * 32'h0101_0101) ^ (32'(idx) << 26);
    endfunction

    function automatic logic is_store(uop_pkg::mem_op_t op);
        return op == uop_pkg::mem_sb || op == uop_pkg::mem_sh || op == uop_pkg::mem_sw;
    endfunction

    function automatic logic is_load(uop_pkg::mem_op_t op);
        return op != uop_pkg::mem_none && !is_store(op);
    endfunction

    function automatic dbus_pkg::data_t merge_bytes(dbus_pkg::data_t old_word,
                                                    dbus_pkg::data_t wdata,
                                                    dbus_pkg::mask_t mask);
        dbus_pkg::data_t w;
        int              b;
        w = old_word;
        for (b = 0; b < 4; b++) begin
            if (mask[b]) w[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return w;
    endfunction

    function automatic dbus_pkg::dbus_req_t expected_req(uop_pkg::uop_t u);
        dbus_pkg::dbus_req_t req;
        uop_pkg::word_t      ea;
        ea        = u.rs1 + u.imm;
        req.addr  = {ea[31:2], 2'b00};
        req.write = is_store(u.mem_op);
        case (u.mem_op)
            uop_pkg::mem_lb, uop_pkg::mem_lbu, uop_pkg::mem_sb: begin
                req.mask  = 4'b0001 << ea[1:0];
                req.wdata = {4{u.rs2[7:0]}};
            end
            uop_pkg::mem_lh, uop_pkg::mem_lhu, uop_pkg::mem_sh: begin
                req.mask  = 4'b0011 << ea[1:0];
                req.wdata = {2{u.rs2[15:0]}};
            end
            default: begin
                req.mask  = 4'b1111;
                req.wdata = u.rs2;
            end
        endcase
        return req;
    endfunction

    function automatic uop_pkg::word_t load_value(uop_pkg::mem_op_t op, dbus_pkg::data_t word,
                                                  logic [1:0] off);
        dbus_pkg::data_t sh;
        sh = word >> {off, 3'b000};
        case (op)
            uop_pkg::mem_lb:  return {{24{sh[7]}}, sh[7:0]};
            uop_pkg::mem_lbu: return {24'd0, sh[7:0]};
            uop_pkg::mem_lh:  return {{16{sh[15]}}, sh[15:0]};
            uop_pkg::mem_lhu: return {16'd0, sh[15:0]};
            default:          return word;
        endcase
    endfunction

    task automatic compare_uop(input string name, input uop_pkg::uop_t exp,
                               input uop_pkg::uop_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_req(input string name, input dbus_pkg::dbus_req_t exp,
                               input dbus_pkg::dbus_req_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic make_uop(output uop_pkg::uop_t u);
        logic [31:0]    r;
        logic [3:0]     op_sel;
        logic [1:0]     off;
        uop_pkg::word_t addr;
        r        = rand_word();
        u.valid  = (r[2:0] != 3'd0);
        op_sel   = 4'(r[31:8] % 9);
        u.mem_op = uop_pkg::mem_op_t'(op_sel);
        u.tag    = tag_cnt;
        tag_cnt  = tag_cnt + 1'b1;
        r        = rand_word();
        case (u.mem_op)   // natural alignment only
            uop_pkg::mem_lb, uop_pkg::mem_lbu, uop_pkg::mem_sb: off = r[1:0];
            uop_pkg::mem_lh, uop_pkg::mem_lhu, uop_pkg::mem_sh: off = {r[1], 1'b0};
            default: off = 2'b00;
        endcase
        addr     = mem_base + {24'd0, r[7:2], 2'b00} + {30'd0, off};
        u.imm    = {{20{r[19]}}, r[19:8]};
        u.rs1    = addr - u.imm;
        u.rs2    = rand_word();
        r        = rand_word();
        u.rd     = r[4:0];
        u.result = rand_word();
    endtask

    // L1 responder with random ready and response delays
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            l1_req_ready_i <= 1'b0;
            l1_rsp_valid_i <= 1'b0;
            req_wait = 0;
            rsp_wait = 0;
        end else begin
            if (l1_rsp_valid_i && l1_rsp_ready_o) begin
                l1_rsp_valid_i <= 1'b0;
            end else if (rsp_wait != 0) begin
                rsp_wait = rsp_wait - 1;
                if (rsp_wait == 0) l1_rsp_valid_i <= 1'b1;
            end
            if (l1_req_valid_o && l1_req_ready_i) begin
                if (l1_req_o.write) begin
                    resp_mem[l1_req_o.addr[7:2]] = merge_bytes(resp_mem[l1_req_o.addr[7:2]],
                                                               l1_req_o.wdata, l1_req_o.mask);
                end else begin
                    rsp_wait = rand_delay();
                    l1_rsp_data_i  <= resp_mem[l1_req_o.addr[7:2]];
                    l1_rsp_valid_i <= (rsp_wait == 0);
                end
                req_wait = rand_delay();
            end else if (req_wait != 0) begin
                req_wait = req_wait - 1;
            end
            l1_req_ready_i <= (req_wait == 0);
        end
    end

    // monitor and reference model sampled at the rising edge
    always @(posedge clk_i) begin
        uop_pkg::uop_t       exp_uop;
        uop_pkg::word_t      ea;
        dbus_pkg::dbus_req_t st_req;
        logic                mem_uop;
        if (rstn_i) begin
            mem_uop = uop_i.valid && uop_i.mem_op != uop_pkg::mem_none;
            compare_bit("wb_uop_o.valid", wb_due, wb_uop_o.valid);
            if (wb_uop_o.valid) begin
                wb_seen++;
                if (wb_queue.size() == 0) begin
                    $display("writeback with tag %h appeared with no uop pending", wb_uop_o.tag);
                    other_errors++;
                end else begin
                    compare_uop("wb_uop_o", wb_queue.pop_front(), wb_uop_o);
                end
            end
            if (!mem_uop) begin   // only memory uops may hold the pipe
                compare_bit("stall_o", 1'b0, stall_o);
            end
            if (hold_pending) begin   // request must stay put until taken
                compare_bit("l1_req_valid_o", 1'b1, l1_req_valid_o);
                compare_req("l1_req_o", held_req, l1_req_o);
            end
            hold_pending = l1_req_valid_o && !l1_req_ready_i;
            held_req     = l1_req_o;
            if (l1_req_valid_o && l1_req_ready_i) begin
                compare_req("l1_req_o", expected_req(uop_i), l1_req_o);
                req_count++;
            end
            wb_due = 1'b0;
            if (!stall_o) begin
                if (req_count != (mem_uop ? 1 : 0)) begin
                    $display("uop with tag %h made %0d requests", uop_i.tag, req_count);
                    other_errors++;
                end
                req_count = 0;
                if (uop_i.valid) begin
                    exp_uop = uop_i;
                    ea      = uop_i.rs1 + uop_i.imm;
                    if (is_store(uop_i.mem_op)) begin
                        st_req             = expected_req(uop_i);
                        model_mem[ea[7:2]] = merge_bytes(model_mem[ea[7:2]], st_req.wdata,
                                                         st_req.mask);
                    end else if (is_load(uop_i.mem_op)) begin
                        exp_uop.result = load_value(uop_i.mem_op, model_mem[ea[7:2]], ea[1:0]);
                    end
                    wb_queue.push_back(exp_uop);
                    wb_due = 1'b1;
                    accepted++;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles with %0d uops accepted", max_cycles, accepted);
            $display("errors: %0d value, %0d other", value_errors, other_errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        uop_pkg::uop_t u;
        int            i;
        int            n;
        seed   = 32'hfeb5;
        rstn_i = 1'b0;
        uop_i  = '0;
        for (i = 0; i < 64; i++) begin
            model_mem[i] = fill_word(i);
            resp_mem[i]  = fill_word(i);
        end
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);
        compare_bit("l1_req_valid_o", 1'b0, l1_req_valid_o);
        compare_bit("l1_rsp_ready_o", 1'b0, l1_rsp_ready_o);
        compare_bit("stall_o", 1'b0, stall_o);
        compare_bit("wb_uop_o.valid", 1'b0, wb_uop_o.valid);
        for (n = 0; n < num_uops; n++) begin
            make_uop(u);
            if (u.valid) issued_valid++;
            uop_i <= u;
            @(posedge clk_i);
            while (stall_o) @(posedge clk_i);   // held until a cycle without stall
        end
        uop_i <= '0;
        repeat (4) @(posedge clk_i);
        if (wb_queue.size() != 0) begin
            $display("%0d writebacks never appeared", wb_queue.size());
            other_errors++;
        end
        if (wb_seen != issued_valid) begin
            $display("issued %0d valid uops but saw %0d writebacks", issued_valid, wb_seen);
            other_errors++;
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
